//--- design/spi_pkg.sv
package spi_pkg;

  // **************************************************
  // Frame format
  // **************************************************
  localparam int cmd_width  = 12; // Command bits shifted out per frame.
  localparam int read_width = 8;  // Bits shifted in after a read command.
  localparam int write_bit  = 11; // A 1 here marks a write frame.

  // **************************************************
  // Timing and queue sizing
  // **************************************************
  localparam int sclk_half_div = 10; // System clocks per SPI half period.

  localparam int cmd_fifo_depth = 4;
  localparam int cmd_fifo_ptr_w = $clog2(cmd_fifo_depth);
  localparam int cmd_fifo_cnt_w = $clog2(cmd_fifo_depth + 1);

  // Frame sequencer states.
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    LEAD,
    SHIFT_OUT,
    SHIFT_IN,
    TRAIL
  } spi_state_e;

endpackage

//--- design/spi_cmd_fifo.sv
`timescale 1ns/1ps

module spi_cmd_fifo (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [spi_pkg::cmd_width-1:0] cmd_in,
  input  logic                         cmd_vld,
  output logic                         cmd_rdy,
  output logic [spi_pkg::cmd_width-1:0] q_cmd,
  output logic                         q_vld,
  input  logic                         q_pop
);

  import spi_pkg::*;

  logic [cmd_width-1:0]      mem [cmd_fifo_depth];
  logic [cmd_fifo_ptr_w-1:0] wr_ptr;
  logic [cmd_fifo_ptr_w-1:0] rd_ptr;
  logic [cmd_fifo_cnt_w-1:0] count;
  logic                      push;
  logic                      pop;

  assign cmd_rdy = (count != cmd_fifo_cnt_w'(cmd_fifo_depth));
  assign q_vld   = (count != '0);
  assign q_cmd   = mem[rd_ptr];

  assign push = cmd_vld && cmd_rdy;
  assign pop  = q_pop && q_vld;

  // **************************************************
  // Storage
  // **************************************************
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= cmd_in;
    end
  end

  // **************************************************
  // Pointers and occupancy
  // **************************************************
  // The depth is a power of two, so the pointers wrap on their own.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:
        begin
          count <= count + 1'b1;
        end
        2'b01:
        begin
          count <= count - 1'b1;
        end
        default:
        begin
          count <= count; // Both or neither leave the level unchanged.
        end
      endcase
    end
  end

endmodule

//--- design/spi_sclk_gen.sv
`timescale 1ns/1ps

module spi_sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_en,
  input  logic toggle_en,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall,
  output logic half_tick
);

  import spi_pkg::*;

  logic [3:0] div_cnt;
  logic       toggle;

  // The strobes come one cycle ahead of the sclk edge they announce.
  assign half_tick = sclk_en && (div_cnt == 4'(sclk_half_div - 1));
  assign toggle    = half_tick && toggle_en;
  assign sclk_rise = toggle && !sclk;
  assign sclk_fall = toggle && sclk;

  // **************************************************
  // Half period divider
  // **************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
    end
    else if (!sclk_en || half_tick)
    begin
      div_cnt <= '0; // Restart at every half period boundary.
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Lead and trail phases tick without moving the clock.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk <= 1'b0;
    end
    else if (!sclk_en)
    begin
      sclk <= 1'b0; // Mode 0 idles low.
    end
    else if (toggle)
    begin
      sclk <= ~sclk;
    end
  end

endmodule

//--- design/spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [spi_pkg::cmd_width-1:0]  q_cmd,
  input  logic                           q_vld,
  output logic                           q_pop,
  output logic                           sclk_en,
  output logic                           toggle_en,
  input  logic                           sclk_rise,
  input  logic                           sclk_fall,
  input  logic                           half_tick,
  output logic                           cs,
  output logic                           mosi,
  input  logic                           miso,
  output logic                           read_vld,
  output logic [spi_pkg::read_width-1:0] read_data
);

  import spi_pkg::*;

  spi_state_e            state;
  spi_state_e            state_nxt;
  logic [cmd_width-1:0]  tx_shift;
  logic [read_width-1:0] rx_shift;
  logic [3:0]            bit_cnt;
  logic                  is_write;
  logic                  out_done;
  logic                  in_done;

  // Bits are counted on falling edges, so a phase ends with sclk low.
  assign out_done = sclk_fall && (bit_cnt == 4'(cmd_width - 1));
  assign in_done  = sclk_fall && (bit_cnt == 4'(read_width - 1));

  assign q_pop     = (state == IDLE) && q_vld;
  assign sclk_en   = (state != IDLE) && (state != LOAD);
  assign toggle_en = (state == SHIFT_OUT) || (state == SHIFT_IN);
  assign read_data = rx_shift; // Stable from the last capture until the next read.

  // **************************************************
  // Frame sequencing
  // **************************************************
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (q_vld)
        begin
          state_nxt = LOAD;
        end
      end
      LOAD:
      begin
        state_nxt = LEAD;
      end
      LEAD:
      begin
        if (half_tick)
        begin
          state_nxt = SHIFT_OUT;
        end
      end
      SHIFT_OUT:
      begin
        if (out_done)
        begin
          state_nxt = is_write ? TRAIL : SHIFT_IN;
        end
      end
      SHIFT_IN:
      begin
        if (in_done)
        begin
          state_nxt = TRAIL;
        end
      end
      TRAIL:
      begin
        if (half_tick)
        begin
          state_nxt = IDLE;
        end
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      cs       <= 1'b1;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
      bit_cnt  <= '0;
      is_write <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      read_vld <= 1'b0;
      case (state)
        LOAD:
        begin
          cs       <= 1'b0;
          mosi     <= tx_shift[cmd_width-1]; // MSB is set up before the first rise.
          is_write <= tx_shift[write_bit];
          bit_cnt  <= '0;
        end
        SHIFT_OUT:
        begin
          if (out_done)
          begin
            mosi    <= 1'b0;
            bit_cnt <= '0;
          end
          else if (sclk_fall)
          begin
            mosi    <= tx_shift[cmd_width-1];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        SHIFT_IN:
        begin
          if (in_done)
          begin
            bit_cnt <= '0;
          end
          else if (sclk_fall)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        TRAIL:
        begin
          if (half_tick)
          begin
            cs       <= 1'b1;
            read_vld <= !is_write; // Only read frames report data.
          end
        end
        default:
        begin
          cs <= cs;
        end
      endcase
    end
  end

  // **************************************************
  // Shift registers
  // **************************************************
  always_ff @(posedge clk)
  begin
    if (q_pop)
    begin
      tx_shift <= q_cmd; // Captured as the entry leaves the queue.
    end
    else if ((state == LOAD) || ((state == SHIFT_OUT) && sclk_fall))
    begin
      tx_shift <= {tx_shift[cmd_width-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == SHIFT_IN) && sclk_rise)
    begin
      rx_shift <= {rx_shift[read_width-2:0], miso};
    end
  end

endmodule

//--- design/spi_subsystem.sv
`timescale 1ns/1ps

module spi_subsystem (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [spi_pkg::cmd_width-1:0]  cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic                           sclk,
  output logic                           cs,
  output logic                           mosi,
  input  logic                           miso,
  output logic                           read_vld,
  output logic [spi_pkg::read_width-1:0] read_data
);

  import spi_pkg::*;

  logic [cmd_width-1:0] q_cmd;
  logic                 q_vld;
  logic                 q_pop;
  logic                 sclk_en;
  logic                 toggle_en;
  logic                 sclk_rise;
  logic                 sclk_fall;
  logic                 half_tick;

  // **************************************************
  // Command queue, sequencer and clock divider
  // **************************************************
  spi_cmd_fifo u_cmd_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .q_cmd   (q_cmd),
    .q_vld   (q_vld),
    .q_pop   (q_pop)
  );

  spi_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .q_cmd     (q_cmd),
    .q_vld     (q_vld),
    .q_pop     (q_pop),
    .sclk_en   (sclk_en),
    .toggle_en (toggle_en),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .half_tick (half_tick),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_sclk_gen u_sclk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk_en   (sclk_en),
    .toggle_en (toggle_en),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .half_tick (half_tick)
  );

endmodule

//--- test/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso,
  output logic len_err
);

  import spi_pkg::*;

  logic [read_width-1:0] regs [8];
  logic [cmd_width-1:0]  frame_cmd;
  logic                  in_frame;
  logic                  miso_q = 1'b0;
  int                    rise_cnt;
  int                    expected_rises;

  assign miso = miso_q;

  // **************************************************
  // Frame receive and length check
  // **************************************************
  initial
  begin
    for (int i = 0; i < 8; i++)
    begin
      regs[i] = '0; // Registers come up cleared.
    end
    len_err   = 1'b0;
    rise_cnt  = 0;
    frame_cmd = '0;
    forever
    begin
      @(negedge cs);
      rise_cnt  = 0;
      frame_cmd = '0;
      in_frame  = 1'b1;
      while (in_frame)
      begin
        @(posedge sclk or posedge cs);
        if (cs)
        begin
          in_frame = 1'b0;
        end
        else
        begin
          rise_cnt = rise_cnt + 1;
          if (rise_cnt <= cmd_width)
          begin
            frame_cmd = {frame_cmd[cmd_width-2:0], mosi}; // MSB arrives first.
            if ((rise_cnt == cmd_width) && frame_cmd[write_bit])
            begin
              regs[frame_cmd[write_bit-1:read_width]] = frame_cmd[read_width-1:0];
            end
          end
        end
      end
      expected_rises = frame_cmd[write_bit] ? cmd_width : cmd_width + read_width;
      if (rise_cnt != expected_rises)
      begin
        $display("SPI slave saw %0d SCLK rises in the frame for command %h, expected %0d",
                 rise_cnt, frame_cmd, expected_rises);
        len_err = 1'b1;
      end
    end
  end

  // Read data leaves on falling edges so the master sees it settled at the next rise.
  always @(negedge sclk)
  begin
    if (!cs && !frame_cmd[write_bit] && (rise_cnt >= cmd_width) &&
        (rise_cnt < cmd_width + read_width))
    begin
      miso_q <= regs[frame_cmd[write_bit-1:read_width]]
                    [3'(cmd_width + read_width - 1 - rise_cnt)];
    end
  end

endmodule

//--- test/tb_spi_subsystem.sv
`timescale 1ns/1ps

module tb_spi_subsystem;

  import spi_pkg::*;

  localparam int num_commands = 58; // 8 + 4 + 6 directed, 40 random.
  localparam int timeout_ns   = num_commands * 420 * 2 * 100;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [cmd_width-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  miso;
  logic                  read_vld;
  logic [read_width-1:0] read_data;
  logic                  len_err;

  logic [read_width-1:0] mirror [8];
  logic [read_width-1:0] expected_q [$];
  logic [read_width-1:0] expected_byte;
  logic                  cs_q = 1'b1;
  int                    seed = 32'hf624;
  int                    frames_done = 0;
  int                    full_cycles = 0;

  always #50 clk = ~clk;

  spi_subsystem DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .sclk    (sclk),
    .cs      (cs),
    .mosi    (mosi),
    .miso    (miso),
    .len_err (len_err)
  );

  // **************************************************
  // Reference model and checking
  // **************************************************
  function automatic logic [read_width-1:0] predict_command(input logic [cmd_width-1:0] cmd);
    logic [2:0]            addr;
    logic [read_width-1:0] result;
    addr   = cmd[10:8];
    result = '0;
    if (cmd[11])
    begin
      mirror[addr] = cmd[7:0];
    end
    else
    begin
      result = mirror[addr];
    end
    return result;
  endfunction

  task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
    if (actual !== expected)
    begin
      $display("Fail at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Called on a falling edge and returns on the falling edge after acceptance.
  task automatic issue_command(input logic [cmd_width-1:0] cmd);
    logic [read_width-1:0] exp_byte;
    exp_byte = predict_command(cmd);
    if (!cmd[11])
    begin
      expected_q.push_back(exp_byte);
    end
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      @(negedge clk);
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  always @(posedge clk)
  begin
    if (rst_n && read_vld)
    begin
      if (expected_q.size() == 0)
      begin
        $display("read_vld pulsed at time %0t with no read outstanding", $time);
        $display("Errors found");
        $fatal(1, "Unexpected read data");
      end
      else
      begin
        expected_byte = expected_q.pop_front();
        compare_values(32'(read_data), 32'(expected_byte), "read_data");
      end
    end
  end

  // Counts finished frames and cycles spent with the queue full.
  always @(posedge clk)
  begin
    cs_q <= cs;
    if (rst_n && cs && !cs_q)
    begin
      frames_done <= frames_done + 1;
    end
    if (rst_n && !cmd_rdy)
    begin
      full_cycles <= full_cycles + 1;
    end
  end

  always @(posedge len_err)
  begin
    $display("SPI frame length check failed in the slave model");
    $display("Errors found");
    $fatal(1, "Bad frame length");
  end

  initial
  begin
    #(timeout_ns);
    $display("Timeout: the commands did not finish within %0d ns", timeout_ns);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

  // **************************************************
  // Stimulus
  // **************************************************
  initial
  begin
    int          full_start;
    int          gap;
    logic [31:0] rnd;
    for (int i = 0; i < 8; i++)
    begin
      mirror[i] = '0;
    end
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    compare_values(32'(cs), 32'd1, "cs after reset");
    compare_values(32'(sclk), 32'd0, "sclk after reset");
    compare_values(32'(read_vld), 32'd0, "read_vld after reset");
    compare_values(32'(cmd_rdy), 32'd1, "cmd_rdy after reset");

    for (int a = 0; a < 8; a++)
    begin
      issue_command({1'b0, 3'(a), 8'h00}); // Untouched registers read zero.
    end

    issue_command({1'b1, 3'd3, 8'ha5});
    issue_command({1'b1, 3'd5, 8'h3c});
    issue_command({1'b0, 3'd3, 8'h00});
    issue_command({1'b0, 3'd5, 8'h00});

    // Six in a row overrun the four-entry queue.
    full_start = full_cycles;
    issue_command({1'b1, 3'd1, 8'h5a});
    issue_command({1'b0, 3'd1, 8'h00});
    issue_command({1'b1, 3'd1, 8'hc3});
    issue_command({1'b0, 3'd1, 8'h00});
    issue_command({1'b1, 3'd2, 8'h7e});
    issue_command({1'b0, 3'd2, 8'h00});
    compare_values(32'(full_cycles > full_start), 32'd1, "cmd_rdy low under back-pressure");

    repeat (40)
    begin
      gap = int'($unsigned($random(seed)) % 300);
      rnd = $random(seed);
      repeat (gap) @(negedge clk);
      issue_command(rnd[cmd_width-1:0]);
    end

    while (frames_done < num_commands)
    begin
      @(negedge clk);
    end
    @(negedge clk);
    if (expected_q.size() == 0)
    begin
      $display("No errors");
      $finish;
    end
    else
    begin
      $display("%0d expected reads never returned data", expected_q.size());
      $display("Errors found");
      $fatal(1, "Missing read data");
    end
  end

endmodule

//--- verilog.f
design/spi_pkg.sv
design/spi_cmd_fifo.sv
design/spi_sclk_gen.sv
design/spi_master.sv
design/spi_subsystem.sv
test/spi_slave_model.sv
test/tb_spi_subsystem.sv

//--- run.sh
#!/bin/sh
# Build and run the SPI subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f verilog.f --top-module tb_spi_subsystem

# A $fatal in the testbench gives a nonzero exit status here.
./obj_dir/Vtb_spi_subsystem
